// File: Bender.yml
package:
  name: arcade_io

export_include_dirs:
  - include

sources:
  - logic/arcade_io_pkg.sv
  - logic/key_decoder.sv
  - logic/game_controls.sv
  - logic/audio_dac.sv
  - logic/video_dimmer.sv
  - logic/arcade_io_top.sv
  - target: test
    files:
      - testbench/arcade_io_sva.sv
      - testbench/arcade_io_tb.sv

// File: arcade_io_top.f
+incdir+include
logic/arcade_io_pkg.sv
logic/key_decoder.sv
logic/game_controls.sv
logic/audio_dac.sv
logic/video_dimmer.sv
logic/arcade_io_top.sv
testbench/arcade_io_sva.sv
testbench/arcade_io_tb.sv

// File: include/arcade_io_settings.svh
// widths and reset stretch length for the arcade platform shell
`ifndef ARCADE_IO_SETTINGS_SVH
`define ARCADE_IO_SETTINGS_SVH

// width of each core sound channel
`define SND_BITS 7

// sigma-delta accumulator input width
`define DAC_BITS 16

// core monochrome pixel width
`define PIX_BITS 8

// colour width per vga channel
`define VGA_BITS 6

// clk_24 cycles core reset is held after all sources clear
`define RST_STRETCH 16

`endif

// File: logic/arcade_io_pkg.sv
// package with ps2 key codes and scanline dimming modes
`default_nettype none

package arcade_io_pkg;

	// ps2 set 2 make codes the shell reacts to
	typedef enum logic [7:0] {
		KEY_ESC   = 8'h76, // coin
		KEY_F1    = 8'h05, // start 1
		KEY_F2    = 8'h06, // start 2
		KEY_CTRL  = 8'h14, // fire 1
		KEY_ALT   = 8'h11, // fire 1 too
		KEY_SPACE = 8'h29  // fire 2
	} key_code_e;

	// attenuation applied to odd lines
	typedef enum logic [1:0] {
		SCAN_OFF = 2'd0,
		SCAN_25  = 2'd1, // level minus a quarter
		SCAN_50  = 2'd2, // half level
		SCAN_75  = 2'd3  // quarter level left
	} scanline_e;

endpackage

`default_nettype wire

// File: logic/arcade_io_top.sv
// top level of the arcade platform shell, controls, audio and video
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_settings.svh"

module arcade_io_top
	import arcade_io_pkg::*;
(
	input  logic                 clk_24,
	input  logic                 rst_n,
	input  logic [10:0]          ps2_key,
	input  logic                 joy_fire1,
	input  logic                 joy_fire2,
	input  logic                 status_reset,
	input  logic                 status_test,
	input  logic                 board_button,
	input  scanline_e            scanline_mode,
	input  logic [`SND_BITS-1:0] core_audio_a,
	input  logic [`SND_BITS-1:0] core_audio_b,
	input  logic                 ce_pix,
	input  logic [`PIX_BITS-1:0] core_pixel,
	input  logic                 core_hblank,
	input  logic                 core_vblank,
	input  logic                 core_hsync,
	input  logic                 core_vsync,
	output logic                 core_reset_n,
	output logic                 coin_n,
	output logic                 start1_n,
	output logic                 start2_n,
	output logic                 fire1_n,
	output logic                 fire2_n,
	output logic                 test_n,
	output logic                 audio_l,
	output logic                 audio_r,
	output logic [`VGA_BITS-1:0] vga_r,
	output logic [`VGA_BITS-1:0] vga_g,
	output logic [`VGA_BITS-1:0] vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs
);

	logic btn_coin;
	logic btn_start1;
	logic btn_start2;
	logic btn_fire1;
	logic btn_fire2;

	key_decoder key_decoder_i (
		.clk_24     (clk_24),
		.rst_n      (rst_n),
		.ps2_key    (ps2_key),
		.btn_coin   (btn_coin),
		.btn_start1 (btn_start1),
		.btn_start2 (btn_start2),
		.btn_fire1  (btn_fire1),
		.btn_fire2  (btn_fire2)
	);

	game_controls game_controls_i (
		.clk_24       (clk_24),
		.rst_n        (rst_n),
		.btn_coin     (btn_coin),
		.btn_start1   (btn_start1),
		.btn_start2   (btn_start2),
		.btn_fire1    (btn_fire1),
		.btn_fire2    (btn_fire2),
		.joy_fire1    (joy_fire1),
		.joy_fire2    (joy_fire2),
		.status_reset (status_reset),
		.status_test  (status_test),
		.board_button (board_button),
		.core_reset_n (core_reset_n),
		.coin_n       (coin_n),
		.start1_n     (start1_n),
		.start2_n     (start2_n),
		.fire1_n      (fire1_n),
		.fire2_n      (fire2_n),
		.test_n       (test_n)
	);

	audio_dac audio_dac_i (
		.clk_24       (clk_24),
		.rst_n        (rst_n),
		.core_audio_a (core_audio_a),
		.core_audio_b (core_audio_b),
		.audio_l      (audio_l)
	);

	assign audio_r = audio_l; // mono board output

	video_dimmer video_dimmer_i (
		.clk_24        (clk_24),
		.rst_n         (rst_n),
		.ce_pix        (ce_pix),
		.core_pixel    (core_pixel),
		.core_hblank   (core_hblank),
		.core_vblank   (core_vblank),
		.core_hsync    (core_hsync),
		.core_vsync    (core_vsync),
		.scanline_mode (scanline_mode),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs)
	);

endmodule

`default_nettype wire

// File: logic/audio_dac.sv
// audio dac, two-channel mix into a first-order sigma-delta bit
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_settings.svh"

module audio_dac (
	input  logic                 clk_24,
	input  logic                 rst_n,
	input  logic [`SND_BITS-1:0] core_audio_a,
	input  logic [`SND_BITS-1:0] core_audio_b,
	output logic                 audio_l
);

	localparam int MIX_W = `SND_BITS + 1;

	logic [MIX_W-1:0]     mix; // sum never overflows
	logic [`DAC_BITS-1:0] sample;
	logic [`DAC_BITS:0]   acc; // top bit is the carry

	assign mix    = MIX_W'(core_audio_a) + MIX_W'(core_audio_b);
	assign sample = {mix, {(`DAC_BITS - MIX_W){1'b0}}};

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			audio_l <= 1'b0;
		end else begin
			acc     <= {1'b0, acc[`DAC_BITS-1:0]} + {1'b0, sample};
			audio_l <= acc[`DAC_BITS];
		end
	end

endmodule

`default_nettype wire

// File: logic/game_controls.sv
// game controls, active-low core inputs and stretched core reset
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_settings.svh"

module game_controls (
	input  logic clk_24,
	input  logic rst_n,
	input  logic btn_coin,
	input  logic btn_start1,
	input  logic btn_start2,
	input  logic btn_fire1,
	input  logic btn_fire2,
	input  logic joy_fire1,
	input  logic joy_fire2,
	input  logic status_reset,
	input  logic status_test,
	input  logic board_button,
	output logic core_reset_n,
	output logic coin_n,
	output logic start1_n,
	output logic start2_n,
	output logic fire1_n,
	output logic fire2_n,
	output logic test_n
);

	localparam int CNT_W = $clog2(`RST_STRETCH + 1);

	logic             rst_src; // any reset request
	logic [CNT_W-1:0] rst_cnt;
	logic             rst_done;

	assign rst_src = status_reset | board_button;

	// counts clear cycles, rst_n itself holds the count at zero
	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			rst_cnt  <= '0;
			rst_done <= 1'b0;
		end else if (rst_src) begin
			rst_cnt  <= '0;
			rst_done <= 1'b0;
		end else if (rst_cnt != CNT_W'(`RST_STRETCH)) begin
			rst_cnt <= rst_cnt + 1'b1;
		end else begin
			rst_done <= 1'b1; // stretch served
		end
	end

	assign core_reset_n = rst_done & ~rst_src;

	assign coin_n   = ~btn_coin;
	assign start1_n = ~btn_start1;
	assign start2_n = ~btn_start2;

	// space fires in the one-player slot
	assign fire1_n = ~(btn_fire2 | joy_fire1);
	assign fire2_n = ~joy_fire2;
	assign test_n  = ~status_test;

endmodule

`default_nettype wire

// File: logic/key_decoder.sv
// key decoder, toggle-strobed ps2 events into held button levels
`timescale 1ns/100ps
`default_nettype none

module key_decoder
	import arcade_io_pkg::*;
(
	input  logic        clk_24,
	input  logic        rst_n,
	input  logic [10:0] ps2_key,
	output logic        btn_coin,
	output logic        btn_start1,
	output logic        btn_start2,
	output logic        btn_fire1,
	output logic        btn_fire2
);

	logic       toggle_q; // toggle bit seen at previous edge
	logic       key_event;
	logic       pressed;
	logic [7:0] code;

	assign pressed   = ps2_key[9];
	assign code      = ps2_key[7:0];
	assign key_event = ps2_key[10] != toggle_q;

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
		end else begin
			toggle_q <= ps2_key[10];
		end
	end

	// one update per toggle flip, the new copy blocks a repeat
	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
			btn_fire1  <= 1'b0;
			btn_fire2  <= 1'b0;
		end else if (key_event) begin
			case (code)
				KEY_ESC:   btn_coin   <= pressed;
				KEY_F1:    btn_start1 <= pressed;
				KEY_F2:    btn_start2 <= pressed;
				KEY_CTRL:  btn_fire1  <= pressed;
				KEY_ALT:   btn_fire1  <= pressed;
				KEY_SPACE: btn_fire2  <= pressed;
				default: begin
					// unknown code, buttons hold
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/video_dimmer.sv
// video dimmer, pixel blanking, line parity and scanline attenuation
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_settings.svh"

module video_dimmer
	import arcade_io_pkg::*;
(
	input  logic                 clk_24,
	input  logic                 rst_n,
	input  logic                 ce_pix,
	input  logic [`PIX_BITS-1:0] core_pixel,
	input  logic                 core_hblank,
	input  logic                 core_vblank,
	input  logic                 core_hsync,
	input  logic                 core_vsync,
	input  scanline_e            scanline_mode,
	output logic [`VGA_BITS-1:0] vga_r,
	output logic [`VGA_BITS-1:0] vga_g,
	output logic [`VGA_BITS-1:0] vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs
);

	logic [`VGA_BITS-1:0] level;
	logic [`VGA_BITS-1:0] dimmed;
	logic [`VGA_BITS-1:0] pix_q;
	logic                 hs_q; // doubles as previous hsync
	logic                 vs_q;
	logic                 odd_line;

	assign level = (core_hblank | core_vblank) ? '0
		: core_pixel[`PIX_BITS-1 -: `VGA_BITS];

	always_comb begin
		dimmed = level;
		if (odd_line) begin
			case (scanline_mode)
				SCAN_25: dimmed = level - (level >> 2);
				SCAN_50: dimmed = level >> 1;
				SCAN_75: dimmed = level >> 2;
				default: dimmed = level;
			endcase
		end
	end

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			pix_q    <= '0;
			hs_q     <= 1'b0;
			vs_q     <= 1'b0;
			odd_line <= 1'b0;
		end else if (ce_pix) begin
			pix_q <= dimmed;
			hs_q  <= core_hsync;
			vs_q  <= core_vsync;
			if (core_vsync && !vs_q) begin
				odd_line <= 1'b0; // new frame starts even
			end else if (core_hsync && !hs_q) begin
				odd_line <= ~odd_line;
			end
		end
	end

	// mono source, same level on all guns
	assign vga_r  = pix_q;
	assign vga_g  = pix_q;
	assign vga_b  = pix_q;
	assign vga_hs = hs_q;
	assign vga_vs = vs_q;

endmodule

`default_nettype wire

// File: testbench/arcade_io_sva.sv
// bound assertions for key decoding, control mapping, reset stretch, audio and video
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_settings.svh"

module arcade_io_sva
	import arcade_io_pkg::*;
(
	input logic                 clk_24,
	input logic                 rst_n,
	input logic [10:0]          ps2_key,
	input logic                 btn_coin, btn_start1, btn_start2, btn_fire1, btn_fire2,
	input logic                 joy_fire1, joy_fire2, status_reset, status_test, board_button,
	input logic [`SND_BITS-1:0] core_audio_a, core_audio_b,
	input logic                 ce_pix, core_hblank, core_vblank, core_hsync, core_vsync,
	input logic [`PIX_BITS-1:0] core_pixel,
	input scanline_e            scanline_mode,
	input logic                 core_reset_n, coin_n, start1_n, start2_n, fire1_n, fire2_n,
	input logic                 test_n, audio_l, audio_r, vga_hs, vga_vs,
	input logic [`VGA_BITS-1:0] vga_r, vga_g, vga_b
);

	localparam int WIN = 1024;

	logic                   tog_q;
	logic [4:0]             btn_m; // coin start1 start2 fire1 fire2
	logic [4:0]             btn_dut;
	logic                   key_event;
	logic                   known;
	logic [5:0]             ctl_exp;
	logic                   rst_exp;
	int                     clear_cnt;
	logic [`SND_BITS:0]     mix_now;
	logic [`SND_BITS:0]     mix_q;
	int                     mix_run; // cycles the mix has held
	logic [WIN-1:0]         hist;
	int                     ones;
	int                     exp_ones;
	logic                   hs_m;
	logic                   vs_m;
	logic                   odd_m;
	logic [`VGA_BITS-1:0]   level;
	logic [`VGA_BITS-1:0]   level_exp;
	logic [`VGA_BITS+1:0]   vga_q; // level, hs, vs

	assign btn_dut   = {btn_coin, btn_start1, btn_start2, btn_fire1, btn_fire2};
	assign key_event = ps2_key[10] ^ tog_q;
	assign known     = ps2_key[7:0] inside {KEY_ESC, KEY_F1, KEY_F2, KEY_CTRL, KEY_ALT, KEY_SPACE};
	assign ctl_exp   = {~btn_coin, ~btn_start1, ~btn_start2, ~(btn_fire2 | joy_fire1),
		~joy_fire2, ~status_test};
	assign rst_exp   = !(status_reset || board_button) && clear_cnt > `RST_STRETCH;
	assign mix_now   = core_audio_a + core_audio_b;
	assign exp_ones  = (int'(mix_q) << (`DAC_BITS - `SND_BITS - 1)) * WIN / (1 << `DAC_BITS);

	always_comb begin
		level = (core_hblank || core_vblank) ? '0
			: core_pixel[`PIX_BITS-1:`PIX_BITS-`VGA_BITS];
		level_exp = level;
		if (odd_m && scanline_mode == SCAN_25) level_exp = level - level / 4;
		if (odd_m && scanline_mode == SCAN_50) level_exp = level / 2;
		if (odd_m && scanline_mode == SCAN_75) level_exp = level / 4;
	end

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			tog_q     <= 1'b0;
			btn_m     <= '0;
			clear_cnt <= 0;
			mix_q     <= '0;
			mix_run   <= 0;
			hist      <= '0;
			ones      <= 0;
			hs_m      <= 1'b0;
			vs_m      <= 1'b0;
			odd_m     <= 1'b0;
			vga_q     <= '0;
		end else begin
			tog_q <= ps2_key[10];
			if (key_event && ps2_key[7:0] == KEY_ESC) btn_m[4] <= ps2_key[9];
			if (key_event && ps2_key[7:0] == KEY_F1) btn_m[3] <= ps2_key[9];
			if (key_event && ps2_key[7:0] == KEY_F2) btn_m[2] <= ps2_key[9];
			if (key_event && ps2_key[7:0] inside {KEY_CTRL, KEY_ALT}) btn_m[1] <= ps2_key[9];
			if (key_event && ps2_key[7:0] == KEY_SPACE) btn_m[0] <= ps2_key[9];
			if (status_reset || board_button) clear_cnt <= 0;
			else if (clear_cnt <= `RST_STRETCH) clear_cnt <= clear_cnt + 1;
			mix_q   <= mix_now;
			mix_run <= (mix_now != mix_q) ? 0 : (mix_run < 2 * WIN) ? mix_run + 1 : mix_run;
			hist    <= {hist[WIN-2:0], audio_l};
			ones    <= ones + int'(audio_l) - int'(hist[WIN-1]); // sliding window count
			if (ce_pix) begin
				hs_m  <= core_hsync;
				vs_m  <= core_vsync;
				vga_q <= {level_exp, core_hsync, core_vsync};
				if (core_vsync && !vs_m) odd_m <= 1'b0;
				else if (core_hsync && !hs_m) odd_m <= ~odd_m;
			end
		end
	end

	a_btn: assert property (@(posedge clk_24) btn_dut == btn_m) else begin
		arcade_io_tb.err_count++;
		$error("[ERROR] btn_* 0x%h expected 0x%h", $sampled(btn_dut), $sampled(btn_m));
	end

	a_unknown: assert property (@(posedge clk_24) disable iff (!rst_n)
		key_event && !known |=> $stable(btn_dut)) else begin
		arcade_io_tb.err_count++;
		$error("an unknown key code changed a button level");
	end

	a_ctl: assert property (@(posedge clk_24)
		{coin_n, start1_n, start2_n, fire1_n, fire2_n, test_n} == ctl_exp) else begin
		arcade_io_tb.err_count++;
		$error("[ERROR] coin_n..test_n 0x%h expected 0x%h",
			$sampled({coin_n, start1_n, start2_n, fire1_n, fire2_n, test_n}), $sampled(ctl_exp));
	end

	a_stretch: assert property (@(posedge clk_24) core_reset_n == rst_exp) else begin
		arcade_io_tb.err_count++;
		$error("[ERROR] core_reset_n 0x%h expected 0x%h", $sampled(core_reset_n), $sampled(rst_exp));
	end

	a_density: assert property (@(posedge clk_24)
		mix_run >= WIN + 4 |-> ones <= exp_ones + 1 && ones + 1 >= exp_ones) else begin
		arcade_io_tb.err_count++;
		$error("[ERROR] audio_l ones 0x%h expected 0x%h", $sampled(ones), $sampled(exp_ones));
	end

	a_silent: assert property (@(posedge clk_24) mix_run >= 4 && mix_q == 0 |-> !audio_l) else begin
		arcade_io_tb.err_count++;
		$error("[ERROR] audio_l 0x%h expected 0x0 on a zero sample", $sampled(audio_l));
	end

	a_mirror: assert property (@(posedge clk_24)
		audio_r == audio_l && vga_g == vga_r && vga_b == vga_r) else begin
		arcade_io_tb.err_count++;
		$error("[ERROR] audio_r vga_g vga_b 0x%h 0x%h 0x%h expected 0x%h 0x%h 0x%h",
			$sampled(audio_r), $sampled(vga_g), $sampled(vga_b),
			$sampled(audio_l), $sampled(vga_r), $sampled(vga_r));
	end

	a_video: assert property (@(posedge clk_24) {vga_r, vga_hs, vga_vs} == vga_q) else begin
		arcade_io_tb.err_count++;
		$error("[ERROR] vga_r,vga_hs,vga_vs 0x%h expected 0x%h",
			$sampled({vga_r, vga_hs, vga_vs}), $sampled(vga_q));
	end

endmodule

`default_nettype wire

// File: testbench/arcade_io_tb.sv
// testbench with clock, reset, lfsr stimulus, timeout and per-test report
`timescale 1ns/100ps
`default_nettype none
`include "arcade_io_settings.svh"

module arcade_io_tb
	import arcade_io_pkg::*;
();

	localparam int KEY_EVENTS   = 64;
	localparam int RST_PULSES   = 16;
	localparam int AUDIO_PAIRS  = 6;
	localparam int AUDIO_HOLD   = 1100; // one window plus pipeline settling
	localparam int BLANK_CYCLES = 400;
	localparam int LINES        = 6;
	localparam int LINE_PX      = 24;
	localparam int RUN_CYCLES   = 60 + KEY_EVENTS * 6 + RST_PULSES * (`RST_STRETCH + 16)
		+ AUDIO_PAIRS * AUDIO_HOLD + BLANK_CYCLES + 4 * (LINES * LINE_PX * 2 + 1);
	localparam int CYCLE_LIMIT  = RUN_CYCLES + RUN_CYCLES / 5;

	logic                 clk_24;
	logic                 rst_n;
	logic [10:0]          ps2_key;
	logic                 joy_fire1, joy_fire2, status_reset, status_test, board_button;
	scanline_e            scanline_mode;
	logic [`SND_BITS-1:0] core_audio_a, core_audio_b;
	logic                 ce_pix, core_hblank, core_vblank, core_hsync, core_vsync;
	logic [`PIX_BITS-1:0] core_pixel;
	logic                 core_reset_n, coin_n, start1_n, start2_n, fire1_n, fire2_n, test_n;
	logic                 audio_l, audio_r, vga_hs, vga_vs;
	logic [`VGA_BITS-1:0] vga_r, vga_g, vga_b;
	logic [31:0]          lfsr;
	int                   err_count; // bumped by the bound assertions
	int                   failed_tests;
	int                   cycle_count;

	arcade_io_top arcade_io_top_i (.*);

	bind arcade_io_top arcade_io_sva arcade_io_sva_i (.*);

	always #10 clk_24 = ~clk_24;

	always @(posedge clk_24) cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("timeout: no verdict after %0d clock cycles", CYCLE_LIMIT);
		$display("sim failed");
		$finish;
	end

	function automatic logic take_bit();
		logic out;
		out  = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) lfsr = lfsr ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], take_bit()};
		return v;
	endfunction

	function automatic logic [7:0] pick_code(input logic [2:0] sel);
		case (sel)
			3'd0: return KEY_ESC;
			3'd1: return KEY_F1;
			3'd2: return KEY_F2;
			3'd3: return KEY_CTRL;
			3'd4: return KEY_ALT;
			3'd5: return KEY_SPACE;
			3'd6: return 8'h1c; // letter a, ignored
			default: return 8'(take_bits(8));
		endcase
	endfunction

	task automatic finish_test(input int num, input string name, input int errs_before);
		repeat (2) @(posedge clk_24);
		if (err_count == errs_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d assertion failures", num, name, err_count - errs_before);
		end
	endtask

	initial begin
		int         base;
		int         w_a;
		int         w_b;
		logic       use_a;
		logic       use_b;
		logic       press;
		logic [7:0] code;
		lfsr          = 32'he962_e397;
		clk_24        = 1'b0;
		rst_n         = 1'b1;
		ps2_key       = '0;
		joy_fire1     = 1'b0;
		joy_fire2     = 1'b0;
		status_reset  = 1'b0;
		status_test   = 1'b0;
		board_button  = 1'b0;
		scanline_mode = SCAN_OFF;
		core_audio_a  = '0;
		core_audio_b  = '0;
		ce_pix        = 1'b0;
		core_pixel    = '0;
		core_hblank   = 1'b0;
		core_vblank   = 1'b0;
		core_hsync    = 1'b0;
		core_vsync    = 1'b0;
		#2 rst_n = 1'b0;
		repeat (3) @(posedge clk_24);
		@(negedge clk_24);
		rst_n = 1'b1;
		while (!core_reset_n) @(negedge clk_24);

		base = err_count;
		for (int i = 0; i < KEY_EVENTS; i++) begin
			@(negedge clk_24);
			press   = take_bit();
			code    = pick_code(3'(take_bits(3)));
			ps2_key = {~ps2_key[10], press, 1'b0, code};
			repeat (take_bits(2) + 1) @(negedge clk_24);
			if (take_bit()) begin
				ps2_key[7:0] = pick_code(3'(take_bits(3))); // new code, toggle held
			end
		end
		finish_test(1, "key decoding", base);

		base = err_count;
		for (int i = 0; i < RST_PULSES; i++) begin
			@(negedge clk_24);
			joy_fire1   = take_bit();
			joy_fire2   = take_bit();
			status_test = take_bit();
			use_a       = take_bit();
			use_b       = take_bit() | ~use_a;
			w_a         = take_bits(3) + 1;
			w_b         = take_bits(3) + 1;
			for (int c = 0; c < 8; c++) begin
				status_reset = use_a && c < w_a;
				board_button = use_b && c < w_b;
				@(negedge clk_24);
			end
			status_reset = 1'b0;
			board_button = 1'b0;
			while (!core_reset_n) @(negedge clk_24);
			repeat (take_bits(2)) @(negedge clk_24);
		end
		finish_test(2, "control mapping and reset stretch", base);

		base = err_count;
		for (int i = 0; i < AUDIO_PAIRS; i++) begin
			@(negedge clk_24);
			core_audio_a = (i == AUDIO_PAIRS - 1) ? '0 : `SND_BITS'(take_bits(`SND_BITS));
			core_audio_b = (i == AUDIO_PAIRS - 1) ? '0 : `SND_BITS'(take_bits(`SND_BITS));
			repeat (AUDIO_HOLD - 1) @(negedge clk_24);
		end
		finish_test(3, "audio density", base);

		base = err_count;
		for (int i = 0; i < BLANK_CYCLES; i++) begin
			@(negedge clk_24);
			ce_pix        = take_bit();
			core_pixel    = `PIX_BITS'(take_bits(`PIX_BITS));
			core_hblank   = take_bit();
			core_vblank   = take_bit();
			scanline_mode = scanline_e'(take_bits(2));
		end
		finish_test(4, "blanking", base);

		base = err_count;
		for (int m = 0; m < 4; m++) begin
			@(negedge clk_24);
			scanline_mode = scanline_e'(m);
			for (int ln = 0; ln < LINES; ln++) begin
				for (int px = 0; px < LINE_PX; px++) begin
					@(negedge clk_24);
					ce_pix      = 1'b1;
					core_pixel  = `PIX_BITS'(take_bits(`PIX_BITS));
					core_hblank = px >= LINE_PX - 6;
					core_vblank = ln == 0;
					core_hsync  = px >= LINE_PX - 4 && px < LINE_PX - 1;
					core_vsync  = ln == 0; // first line of each frame
					@(negedge clk_24);
					ce_pix = 1'b0;
				end
			end
		end
		finish_test(5, "scanline dimming", base);

		$display("tests 5, failed %0d, assertion failures %0d", failed_tests, err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
